// ==== list.f ====
+incdir+common
common/core_types_pkg.sv
common/pipe_pkg.sv
ibuf/inst_buffer.sv
issue/regfile.sv
issue/issue_stage.sv
logic/exec_lane.sv
logic/commit_unit.sv
logic/dual_issue_core.sv
dv/core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module core_tb \
    && ./obj_dir/Vcore_tb | tee /dev/stderr | grep -q "Simulation passed" \
    && exit 0 || exit 1

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps

`include "core_params.svh"

module core_tb import core_types_pkg::*; import pipe_pkg::*;;

    localparam int N_INST  = 160;
    localparam int TIMEOUT = 20 * N_INST + 50;

    logic        clk;
    logic        reset;
    logic [1:0]  fetch_size;
    fetch_slot_t fetch [2];
    logic        fetch_ready;
    wb_debug_t   wb [`NUM_LANES];

    integer seed = 32'h52be;
    int     cycles = 0;
    logic   saw_not_ready = 1'b0;
    inst_t  prog [N_INST + 2];
    int     kind [N_INST];
    word_t  model_regs [`NUM_REGS];
    pc_t    exp_pc [$];
    int     exp_rd [$];
    word_t  exp_val [$];

    dual_issue_core UUT (
        .clk           (clk),
        .reset         (reset),
        .i_fetch_size  (fetch_size),
        .i_fetch       (fetch),
        .o_fetch_ready (fetch_ready),
        .o_wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic inst_t enc_3r(logic [16:0] opc, logic [4:0] rk, logic [4:0] rj,
                                     logic [4:0] rd);
        return {opc, rk, rj, rd};
    endfunction

    function automatic inst_t enc_addi(logic [11:0] imm, logic [4:0] rj, logic [4:0] rd);
        return {10'h00a, imm, rj, rd};
    endfunction

    // kinds 0 to 4 are the 3R ops, 5 is addi.w, 6 an unknown word, 7 an add.w fed by
    // the previous instruction's rd.
    task automatic build_program();
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        for (int i = 0; i < N_INST; i++) begin
            kind[i] = (i < 8) ? (i + 5) % 8 : {$random(seed)} % 8;
            rd = 5'({$random(seed)} % 8);
            rj = 5'({$random(seed)} % 8);
            rk = 5'({$random(seed)} % 8);
            case (kind[i])
                0: prog[i] = enc_3r(17'h00020, rk, rj, rd);
                1: prog[i] = enc_3r(17'h00022, rk, rj, rd);
                2: prog[i] = enc_3r(17'h00029, rk, rj, rd);
                3: prog[i] = enc_3r(17'h0002a, rk, rj, rd);
                4: prog[i] = enc_3r(17'h0002b, rk, rj, rd);
                5: prog[i] = enc_addi(12'($random(seed)), rj, rd);
                6: prog[i] = {10'h3ff, 22'($random(seed))};
                default: prog[i] = enc_3r(17'h00020, rk, (i > 0) ? prog[i-1][4:0] : rj, rd);
            endcase
        end
        prog[N_INST] = '0;
        prog[N_INST + 1] = '0;
    endtask

    task automatic run_model();
        inst_t inst;
        word_t a;
        word_t b;
        word_t val;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < N_INST; i++) begin
            inst = prog[i];
            a = model_regs[inst[9:5]];
            b = model_regs[inst[14:10]];
            case (kind[i])
                1: val = a - b;
                2: val = a & b;
                3: val = a | b;
                4: val = a ^ b;
                5: val = a + 32'($signed(inst[21:10]));
                default: val = a + b;
            endcase
            if (kind[i] != 6 && inst[4:0] != 5'd0) begin
                model_regs[inst[4:0]] = val;
                exp_pc.push_back(32'h1c00_0000 + 4 * i);
                exp_rd.push_back(inst[4:0]);
                exp_val.push_back(val);
            end
        end
    endtask

    task automatic fail_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("** Error: %s expected %h actual %h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_lane(input int l);
        if (wb[l].wen != 4'h0) begin
            assert (wb[l].wen == 4'hf) else fail_value("debug wen", 32'hf, 32'(wb[l].wen));
            assert (exp_pc.size() != 0) else begin
                $display("lane %0d committed pc %h but no write was expected", l, wb[l].pc);
                $display("Simulation failed");
                $fatal(1);
            end
            assert (wb[l].pc == exp_pc[0]) else fail_value("commit pc", exp_pc[0], wb[l].pc);
            assert (wb[l].wnum == exp_rd[0])
                else fail_value("commit rd", exp_rd[0], 32'(wb[l].wnum));
            assert (wb[l].wdata == exp_val[0])
                else fail_value("commit value", exp_val[0], wb[l].wdata);
            void'(exp_pc.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_val.pop_front());
        end
    endtask

    // outputs change on the rising edge, so records are compared on the falling one.
    always @(negedge clk) begin
        if (!reset) begin
            check_lane(0);
            check_lane(1);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, %0d commits missing", cycles, exp_pc.size());
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        int idx;
        int size;
        reset = 1'b1;
        fetch_size = 2'd0;
        fetch[0] = '0;
        fetch[1] = '0;
        build_program();
        run_model();
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        repeat (5) begin
            @(negedge clk);
            assert (fetch_ready) else fail_value("idle ready", 32'h1, 32'(fetch_ready));
            assert (wb[0].wen == 4'h0 && wb[1].wen == 4'h0)
                else fail_value("idle wen", 32'h0, 32'({wb[0].wen, wb[1].wen}));
        end
        idx = 0;
        while (idx < N_INST) begin
            @(posedge clk);
            #2;
            size = 0;
            if (fetch_ready) begin
                // the second half is a burst that fills the buffer.
                size = (idx >= N_INST / 2) ? 2 : {$random(seed)} % 3;
                if (size > N_INST - idx) begin
                    size = N_INST - idx;
                end
            end else begin
                saw_not_ready = 1'b1;
            end
            for (int s = 0; s < 2; s++) begin
                fetch[s].pc = 32'h1c00_0000 + 4 * (idx + s);
                fetch[s].inst = prog[idx + s];
            end
            fetch_size = size[1:0];
            idx += size;
        end
        @(posedge clk);
        #2 fetch_size = 2'd0;
        while (exp_pc.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (!saw_not_ready) begin
            $display("fetch ready never dropped during the burst");
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== logic/dual_issue_core.sv ====
`timescale 1ns/1ps

`include "core_params.svh"

module dual_issue_core import pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic [1:0]  i_fetch_size,
    input  fetch_slot_t i_fetch [2],
    output logic        o_fetch_ready,

    output wb_debug_t   o_wb [`NUM_LANES]
);

    logic [1:0]   head_valid;
    fetch_slot_t  head [2];
    logic [1:0]   consume;
    issue_pkt_t   issue [`NUM_LANES];
    lane_result_t result [`NUM_LANES];
    rf_write_t    rf_write [`NUM_LANES];

    inst_buffer #(
        .DEPTH(`IBUF_DEPTH)
    ) ibuf_0 (
        .clk           (clk),
        .reset         (reset),
        .i_fetch_size  (i_fetch_size),
        .i_fetch       (i_fetch),
        .o_fetch_ready (o_fetch_ready),
        .o_head_valid  (head_valid),
        .o_head        (head),
        .i_consume     (consume)
    );

    issue_stage issue_0 (
        .clk          (clk),
        .reset        (reset),
        .i_head_valid (head_valid),
        .i_head       (head),
        .o_consume    (consume),
        .i_rf_write   (rf_write),
        .o_issue      (issue)
    );

    // lane 0 always holds the older instruction of a pair.
    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
        exec_lane lane (
            .clk      (clk),
            .reset    (reset),
            .i_issue  (issue[l]),
            .o_result (result[l])
        );
    end

    commit_unit commit_0 (
        .clk        (clk),
        .reset      (reset),
        .i_result   (result),
        .o_rf_write (rf_write),
        .o_wb       (o_wb)
    );

endmodule

// ==== logic/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit import pipe_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  lane_result_t i_result [2],
    output rf_write_t    o_rf_write [2],
    output wb_debug_t    o_wb [2]
);

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            o_rf_write[l].we    = i_result[l].valid && i_result[l].wen;
            o_rf_write[l].waddr = i_result[l].dest;
            o_rf_write[l].wdata = i_result[l].result;
        end
    end

    // debug records trail the regfile write by one cycle.
    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            o_wb[l].pc    <= i_result[l].pc;
            o_wb[l].wnum  <= i_result[l].dest;
            o_wb[l].wdata <= i_result[l].result;
        end
        if (reset) begin
            for (int l = 0; l < 2; l++) begin
                o_wb[l].wen <= 4'h0;
            end
        end else begin
            for (int l = 0; l < 2; l++) begin
                o_wb[l].wen <= {4{o_rf_write[l].we}};
            end
        end
    end

endmodule

// ==== logic/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane import core_types_pkg::*; import pipe_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  issue_pkt_t   i_issue,
    output lane_result_t o_result
);

    alu_op_t   op;
    word_t     imm;
    word_t     alu_out;
    reg_addr_t dest;
    logic      writes;

    assign op   = decode_op(i_issue.inst);
    assign dest = i_issue.inst[4:0];

    // si12 of the 2RI12 format.
    assign imm = {{20{i_issue.inst[21]}}, i_issue.inst[21:10]};

    assign writes = i_issue.valid && op != OP_NOP && dest != '0;

    always_comb begin
        case (op)
            OP_ADD:  alu_out = i_issue.src1 + i_issue.src2;
            OP_SUB:  alu_out = i_issue.src1 - i_issue.src2;
            OP_AND:  alu_out = i_issue.src1 & i_issue.src2;
            OP_OR:   alu_out = i_issue.src1 | i_issue.src2;
            OP_XOR:  alu_out = i_issue.src1 ^ i_issue.src2;
            OP_ADDI: alu_out = i_issue.src1 + imm;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        o_result.pc     <= i_issue.pc;
        o_result.dest   <= dest;
        o_result.result <= alu_out;
        if (reset) begin
            o_result.valid <= 1'b0;
            o_result.wen   <= 1'b0;
        end else begin
            o_result.valid <= i_issue.valid;
            o_result.wen   <= writes;
        end
    end

endmodule

// ==== issue/issue_stage.sv ====
`timescale 1ns/1ps

`include "core_params.svh"

module issue_stage import core_types_pkg::*; import pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic [1:0]  i_head_valid,
    input  fetch_slot_t i_head [2],
    output logic [1:0]  o_consume,

    input  rf_write_t   i_rf_write [`NUM_LANES],
    output issue_pkt_t  o_issue [`NUM_LANES]
);

    logic [`NUM_REGS-1:0] busy;
    logic [`NUM_REGS-1:0] clear_mask;
    logic [`NUM_REGS-1:0] set_mask;
    logic [`NUM_REGS-1:0] live_busy;

    reg_addr_t  rj [2];
    reg_addr_t  rk [2];
    reg_addr_t  rd [2];
    logic [1:0] writes;
    logic [1:0] hazard;
    logic [1:0] issue_ok;

    reg_addr_t  rf_raddr [4];
    word_t      rf_rdata [4];
    logic [1:0] rf_we;
    reg_addr_t  rf_waddr [2];
    word_t      rf_wdata [2];

    always_comb begin
        clear_mask = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            rf_we[l]    = i_rf_write[l].we;
            rf_waddr[l] = i_rf_write[l].waddr;
            rf_wdata[l] = i_rf_write[l].wdata;
            if (i_rf_write[l].we) begin
                clear_mask[i_rf_write[l].waddr] = 1'b1;
            end
        end
    end

    // a register being written back now is free, the regfile bypass covers it.
    assign live_busy = busy & ~clear_mask;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rd[s] = i_head[s].inst[4:0];
            rj[s] = i_head[s].inst[9:5];
            rk[s] = i_head[s].inst[14:10];
            writes[s] = (decode_op(i_head[s].inst) != OP_NOP) && (rd[s] != '0);
            hazard[s] = live_busy[rj[s]] | live_busy[rk[s]] | live_busy[rd[s]];
            rf_raddr[2*s]     = rj[s];
            rf_raddr[2*s + 1] = rk[s];
        end
    end

    // the younger slot also stays back on any overlap with the older rd.
    assign issue_ok[0] = i_head_valid[0] && !hazard[0];
    assign issue_ok[1] = issue_ok[0] && i_head_valid[1] && !hazard[1]
                      && rj[1] != rd[0] && rk[1] != rd[0] && rd[1] != rd[0];

    assign o_consume = issue_ok[1] ? 2'd2 : (issue_ok[0] ? 2'd1 : 2'd0);

    always_comb begin
        set_mask = '0;
        for (int s = 0; s < 2; s++) begin
            if (issue_ok[s] && writes[s]) begin
                set_mask[rd[s]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            o_issue[l].pc   <= i_head[l].pc;
            o_issue[l].inst <= i_head[l].inst;
            o_issue[l].src1 <= rf_rdata[2*l];
            o_issue[l].src2 <= rf_rdata[2*l + 1];
        end
        if (reset) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                o_issue[l].valid <= 1'b0;
            end
            busy <= '0;
        end else begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                o_issue[l].valid <= issue_ok[l];
            end
            busy <= live_busy | set_mask;
        end
    end

    regfile regfile_0 (
        .clk     (clk),
        .i_raddr (rf_raddr),
        .o_rdata (rf_rdata),
        .i_we    (rf_we),
        .i_waddr (rf_waddr),
        .i_wdata (rf_wdata)
    );

endmodule

// ==== issue/regfile.sv ====
`timescale 1ns/1ps

`include "core_params.svh"

module regfile import core_types_pkg::*; (
    input  logic       clk,
    input  reg_addr_t  i_raddr [4],
    output word_t      o_rdata [4],
    input  logic [1:0] i_we,
    input  reg_addr_t  i_waddr [2],
    input  word_t      i_wdata [2]
);

    word_t regs [`NUM_REGS];

    // registers start at zero, as the architecture expects after reset.
    initial begin
        for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (i_we[w] && i_waddr[w] != '0) begin
                regs[i_waddr[w]] <= i_wdata[w];
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (i_raddr[p] == '0) begin
                o_rdata[p] = '0;
            end else if (i_we[1] && i_waddr[1] == i_raddr[p]) begin
                o_rdata[p] = i_wdata[1];
            end else if (i_we[0] && i_waddr[0] == i_raddr[p]) begin
                o_rdata[p] = i_wdata[0];
            end else begin
                o_rdata[p] = regs[i_raddr[p]];
            end
        end
    end

endmodule

// ==== ibuf/inst_buffer.sv ====
`timescale 1ns/1ps

`include "core_params.svh"

module inst_buffer import pipe_pkg::*; #(
    parameter int DEPTH = `IBUF_DEPTH
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [1:0]  i_fetch_size,
    input  fetch_slot_t i_fetch [2],
    output logic        o_fetch_ready,

    output logic [1:0]  o_head_valid,
    output fetch_slot_t o_head [2],
    input  logic [1:0]  i_consume
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] READY_LIMIT = (PTR_W + 1)'(DEPTH - 2);

    fetch_slot_t      mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [1:0]       push;

    // room for a full pair is required, whatever size is offered.
    assign o_fetch_ready = count <= READY_LIMIT;
    assign push = o_fetch_ready ? i_fetch_size : 2'd0;

    assign o_head[0] = mem[rd_ptr];
    assign o_head[1] = mem[rd_ptr + PTR_W'(1)];
    assign o_head_valid = {count >= (PTR_W + 1)'(2), count != '0};

    always_ff @(posedge clk) begin
        if (push != 2'd0) begin
            mem[wr_ptr] <= i_fetch[0];
        end
        if (push == 2'd2) begin
            mem[wr_ptr + PTR_W'(1)] <= i_fetch[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push);
            rd_ptr <= rd_ptr + PTR_W'(i_consume);
            count  <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(i_consume);
        end
    end

endmodule

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    import core_types_pkg::*;

    // one instruction as delivered by the fetch source.
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } fetch_slot_t;

    // one instruction leaving issue with its operands already read.
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        inst_t inst;
        word_t src1;
        word_t src2;
    } issue_pkt_t;

    // wen is already low for nops and for writes to r0.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        logic      wen;
        reg_addr_t dest;
        word_t     result;
    } lane_result_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    // debug write-back record, wen is a byte mask like the bus it mimics.
    typedef struct packed {
        pc_t        pc;
        logic [3:0] wen;
        reg_addr_t  wnum;
        word_t      wdata;
    } wb_debug_t;

endpackage

// ==== common/core_types_pkg.sv ====
package core_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_NOP
    } alu_op_t;

    // 3R ops sit in bits 31 to 15, addi.w in bits 31 to 22.
    function automatic alu_op_t decode_op(inst_t inst);
        alu_op_t op;
        op = OP_NOP;
        if (inst[31:22] == 10'h00a) begin
            op = OP_ADDI;
        end else begin
            case (inst[31:15])
                17'h00020: op = OP_ADD;
                17'h00022: op = OP_SUB;
                17'h00029: op = OP_AND;
                17'h0002a: op = OP_OR;
                17'h0002b: op = OP_XOR;
                default:   op = OP_NOP;
            endcase
        end
        return op;
    endfunction

endpackage

// ==== common/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// instruction buffer entries, kept a power of two so the pointers wrap.
`define IBUF_DEPTH 8

// execution lanes, which is also the widest issue group.
`define NUM_LANES 2

// architectural integer registers.
`define NUM_REGS 32

`endif
